// ==== filelist.f ====
logic/decode_pkg.sv
logic/decode_in_reg.sv
logic/inst_classify.sv
logic/operand_bypass.sv
logic/branch_resolve.sv
logic/decode_out_reg.sv
logic/decode_stage.sv
verif/decode_stage_assertions.sv
verif/decode_stage_tb.sv

// ==== Makefile ====
# Verilator build and run for the decode stage

VERILATOR ?= verilator
TOP       ?= decode_stage_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the log decides pass or fail
run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "TESTS PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/decode_stage_tb.sv ====
/*
 * decode stage testbench
 * vector table through the DUT with and without execute back-pressure
 */
`timescale 1ns/100ps

module decode_stage_tb;

  localparam int unsigned NUM_BYPASS = decode_pkg::DEF_NUM_BYPASS;
  localparam int unsigned NUM_SETS   = 5;

  typedef struct {
    decode_pkg::fetch_pkt_t  fetch;
    int unsigned             bp_set;
    decode_pkg::decode_pkt_t exp;
    decode_pkg::reg_addr_t   exp_rs1;
    decode_pkg::reg_addr_t   exp_rs2;
  } vec_t;

  logic                    clk = 1'b0;
  logic                    rst_n_i;
  logic                    in_valid_i;
  logic                    in_ready_o;
  decode_pkg::fetch_pkt_t  in_pkt_i;
  decode_pkg::reg_addr_t   rf_rs1_addr_o;
  decode_pkg::reg_addr_t   rf_rs2_addr_o;
  decode_pkg::xlen_t       rf_rs1_data_i;
  decode_pkg::xlen_t       rf_rs2_data_i;
  decode_pkg::bypass_t     bypass_i [NUM_BYPASS];
  logic                    out_valid_o;
  logic                    out_ready_i;
  decode_pkg::decode_pkt_t out_pkt_o;

  vec_t                vecs[$];
  decode_pkg::bypass_t bp_sets [NUM_SETS][NUM_BYPASS];
  integer              seed;
  bit                  table_ready = 1'b0;

  always #10 clk = ~clk;

  decode_stage #(
    .NUM_BYPASS (NUM_BYPASS)
  ) decode_stage_i (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .in_valid_i    (in_valid_i),
    .in_ready_o    (in_ready_o),
    .in_pkt_i      (in_pkt_i),
    .rf_rs1_addr_o (rf_rs1_addr_o),
    .rf_rs2_addr_o (rf_rs2_addr_o),
    .rf_rs1_data_i (rf_rs1_data_i),
    .rf_rs2_data_i (rf_rs2_data_i),
    .bypass_i      (bypass_i),
    .out_valid_o   (out_valid_o),
    .out_ready_i   (out_ready_i),
    .out_pkt_o     (out_pkt_o)
  );

  // register file model, x0 reads as zero
  function automatic decode_pkg::xlen_t rf_read(input decode_pkg::reg_addr_t addr);
    if (addr == '0) begin
      return '0;
    end else begin
      return {59'd0, addr} * 64'h1111;
    end
  endfunction

  assign rf_rs1_data_i = rf_read(rf_rs1_addr_o);
  assign rf_rs2_data_i = rf_read(rf_rs2_addr_o);

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic compare_word(input string name, input decode_pkg::xlen_t exp,
                              input decode_pkg::xlen_t got);
    if (got !== exp) begin
      fail_now($sformatf("mismatch at %0d ns: %s expected %h got %h", $time, name, exp, got));
    end
  endtask

  task automatic check_pkt(input int unsigned idx, input decode_pkg::decode_pkt_t exp,
                           input decode_pkg::decode_pkt_t got);
    compare_word($sformatf("out_pkt_o.pc [%0d]", idx), exp.pc, got.pc);
    compare_word($sformatf("out_pkt_o.cls [%0d]", idx), {60'd0, exp.cls}, {60'd0, got.cls});
    compare_word($sformatf("out_pkt_o.funct3 [%0d]", idx), {61'd0, exp.funct3},
                 {61'd0, got.funct3});
    compare_word($sformatf("out_pkt_o.op1 [%0d]", idx), exp.op1, got.op1);
    compare_word($sformatf("out_pkt_o.op2 [%0d]", idx), exp.op2, got.op2);
    compare_word($sformatf("out_pkt_o.rd_we [%0d]", idx), {63'd0, exp.rd_we},
                 {63'd0, got.rd_we});
    compare_word($sformatf("out_pkt_o.rd_addr [%0d]", idx), {59'd0, exp.rd_addr},
                 {59'd0, got.rd_addr});
  endtask

  // target only matters when a redirect is requested
  task automatic check_redirect(input int unsigned idx, input logic exp_flag,
                                input decode_pkg::xlen_t exp_pc, input logic got_flag,
                                input decode_pkg::xlen_t got_pc);
    compare_word($sformatf("out_pkt_o.redirect [%0d]", idx), {63'd0, exp_flag},
                 {63'd0, got_flag});
    if (exp_flag) begin
      compare_word($sformatf("out_pkt_o.redirect_pc [%0d]", idx), exp_pc, got_pc);
    end
  endtask

  task automatic check_rf_addr(input int unsigned idx, input decode_pkg::reg_addr_t exp_rs1,
                               input decode_pkg::reg_addr_t exp_rs2,
                               input decode_pkg::reg_addr_t got_rs1,
                               input decode_pkg::reg_addr_t got_rs2);
    compare_word($sformatf("rf_rs1_addr_o [%0d]", idx), {59'd0, exp_rs1}, {59'd0, got_rs1});
    compare_word($sformatf("rf_rs2_addr_o [%0d]", idx), {59'd0, exp_rs2}, {59'd0, got_rs2});
  endtask

  task automatic add_vec(input decode_pkg::xlen_t pc, input logic [31:0] inst,
                         input logic pred, input int unsigned bp_set,
                         input decode_pkg::inst_class_e cls, input decode_pkg::xlen_t op1,
                         input decode_pkg::xlen_t op2, input logic rd_we,
                         input decode_pkg::reg_addr_t rd_addr, input logic redirect,
                         input decode_pkg::xlen_t redirect_pc);
    vec_t v;
    v.fetch.pc         = pc;
    v.fetch.inst       = inst;
    v.fetch.pred_taken = pred;
    v.bp_set           = bp_set;
    v.exp              = '0;
    v.exp.pc           = pc;
    v.exp.cls          = cls;
    v.exp.funct3       = inst[14:12];
    v.exp.op1          = op1;
    v.exp.op2          = op2;
    v.exp.rd_we        = rd_we;
    v.exp.rd_addr      = rd_addr;
    v.exp.redirect     = redirect;
    v.exp.redirect_pc  = redirect_pc;
    // unread source operands present index 0 to the register file
    v.exp_rs1 = '0;
    v.exp_rs2 = '0;
    if (cls inside {decode_pkg::CLS_ALU_REG, decode_pkg::CLS_ALU_IMM,
                    decode_pkg::CLS_ALU_REG_W, decode_pkg::CLS_ALU_IMM_W,
                    decode_pkg::CLS_BRANCH, decode_pkg::CLS_LOAD,
                    decode_pkg::CLS_STORE, decode_pkg::CLS_JALR}) begin
      v.exp_rs1 = inst[19:15];
    end
    if (cls inside {decode_pkg::CLS_ALU_REG, decode_pkg::CLS_ALU_REG_W,
                    decode_pkg::CLS_BRANCH, decode_pkg::CLS_STORE}) begin
      v.exp_rs2 = inst[24:20];
    end
    vecs.push_back(v);
  endtask

  task automatic load_bypass_sets();
    for (int s = 0; s < NUM_SETS; s++) begin
      for (int j = 0; j < NUM_BYPASS; j++) begin
        bp_sets[s][j] = '0;
      end
    end
    // x5 in sources 0 and 2, source 1 matches but is disabled
    bp_sets[1][0] = {1'b1, 5'd5, 64'hAAAA_0000_0000_0008};
    bp_sets[1][1] = {1'b0, 5'd5, 64'h1111_1111_1111_1111};
    bp_sets[1][2] = {1'b1, 5'd5, 64'hCCCC_0000_0000_000C};
    bp_sets[2][0] = {1'b1, 5'd6, 64'h6666_0000_0000_0000};
    bp_sets[2][2] = {1'b1, 5'd5, 64'hCCCC_0000_0000_000C};
    // forwarding to x0 must be ignored
    bp_sets[3][0] = {1'b1, 5'd0, 64'hDEAD_BEEF_DEAD_BEEF};
    // negative x1 for the signed/unsigned branch compares
    bp_sets[4][1] = {1'b1, 5'd1, 64'hFFFF_FFFF_FFFF_FFF0};
    bp_sets[4][2] = {1'b1, 5'd1, 64'h0000_0000_0000_0123};
  endtask

  task automatic fill_table();
    add_vec(64'h1000, 32'h002081B3, 1'b0, 0, decode_pkg::CLS_ALU_REG, 64'h1111, 64'h2222,
            1'b1, 5'd3, 1'b0, 64'h0);
    add_vec(64'h1004, 32'hFFF08213, 1'b0, 0, decode_pkg::CLS_ALU_IMM, 64'h1111,
            64'hFFFF_FFFF_FFFF_FFFF, 1'b1, 5'd4, 1'b0, 64'h0);
    add_vec(64'h1008, 32'h7FF1029B, 1'b0, 0, decode_pkg::CLS_ALU_IMM_W, 64'h2222, 64'h7FF,
            1'b1, 5'd5, 1'b0, 64'h0);
    add_vec(64'h100C, 32'h4083833B, 1'b0, 0, decode_pkg::CLS_ALU_REG_W, 64'h7777, 64'h8888,
            1'b1, 5'd6, 1'b0, 64'h0);
    add_vec(64'h1010, 32'h800004B7, 1'b0, 0, decode_pkg::CLS_LUI, 64'h0,
            64'hFFFF_FFFF_8000_0000, 1'b1, 5'd9, 1'b0, 64'h0);
    add_vec(64'h2000, 32'h12345517, 1'b0, 0, decode_pkg::CLS_AUIPC, 64'h2000, 64'h1234_5000,
            1'b1, 5'd10, 1'b0, 64'h0);
    add_vec(64'h3000, 32'h000000EF, 1'b0, 0, decode_pkg::CLS_JAL, 64'h3000, 64'h3000,
            1'b1, 5'd1, 1'b0, 64'h0);
    add_vec(64'h1014, 32'h00813583, 1'b0, 0, decode_pkg::CLS_LOAD, 64'h2222, 64'h8,
            1'b1, 5'd11, 1'b0, 64'h0);
    add_vec(64'h1018, 32'h00C1B823, 1'b0, 0, decode_pkg::CLS_STORE, 64'h3333, 64'hCCCC,
            1'b0, 5'd0, 1'b0, 64'h0);
    add_vec(64'h101C, 32'h00000001, 1'b0, 0, decode_pkg::CLS_NONE, 64'h0, 64'h0,
            1'b0, 5'd0, 1'b0, 64'h0);
    // forwarding priority on rs1 = x5
    add_vec(64'h1020, 32'h002286B3, 1'b0, 1, decode_pkg::CLS_ALU_REG, 64'hAAAA_0000_0000_0008,
            64'h2222, 1'b1, 5'd13, 1'b0, 64'h0);
    add_vec(64'h1024, 32'h002286B3, 1'b0, 2, decode_pkg::CLS_ALU_REG, 64'hCCCC_0000_0000_000C,
            64'h2222, 1'b1, 5'd13, 1'b0, 64'h0);
    add_vec(64'h1028, 32'h002286B3, 1'b0, 0, decode_pkg::CLS_ALU_REG, 64'h5555, 64'h2222,
            1'b1, 5'd13, 1'b0, 64'h0);
    add_vec(64'h102C, 32'h002006B3, 1'b0, 3, decode_pkg::CLS_ALU_REG, 64'h0, 64'h2222,
            1'b1, 5'd13, 1'b0, 64'h0);
    // branches at 0x4000, offset -16, x1 = -16, x2 = 0x2222
    add_vec(64'h4000, 32'hFE2088E3, 1'b0, 4, decode_pkg::CLS_BRANCH, 64'hFFFF_FFFF_FFFF_FFF0,
            64'h2222, 1'b0, 5'd0, 1'b0, 64'h0);
    add_vec(64'h4000, 32'hFE2088E3, 1'b1, 4, decode_pkg::CLS_BRANCH, 64'hFFFF_FFFF_FFFF_FFF0,
            64'h2222, 1'b0, 5'd0, 1'b1, 64'h4004);
    add_vec(64'h4000, 32'hFE2098E3, 1'b0, 4, decode_pkg::CLS_BRANCH, 64'hFFFF_FFFF_FFFF_FFF0,
            64'h2222, 1'b0, 5'd0, 1'b1, 64'h3FF0);
    add_vec(64'h4000, 32'hFE2098E3, 1'b1, 4, decode_pkg::CLS_BRANCH, 64'hFFFF_FFFF_FFFF_FFF0,
            64'h2222, 1'b0, 5'd0, 1'b0, 64'h0);
    add_vec(64'h4000, 32'hFE20C8E3, 1'b0, 4, decode_pkg::CLS_BRANCH, 64'hFFFF_FFFF_FFFF_FFF0,
            64'h2222, 1'b0, 5'd0, 1'b1, 64'h3FF0);
    add_vec(64'h4000, 32'hFE20C8E3, 1'b1, 4, decode_pkg::CLS_BRANCH, 64'hFFFF_FFFF_FFFF_FFF0,
            64'h2222, 1'b0, 5'd0, 1'b0, 64'h0);
    add_vec(64'h4000, 32'hFE20D8E3, 1'b0, 4, decode_pkg::CLS_BRANCH, 64'hFFFF_FFFF_FFFF_FFF0,
            64'h2222, 1'b0, 5'd0, 1'b0, 64'h0);
    add_vec(64'h4000, 32'hFE20D8E3, 1'b1, 4, decode_pkg::CLS_BRANCH, 64'hFFFF_FFFF_FFFF_FFF0,
            64'h2222, 1'b0, 5'd0, 1'b1, 64'h4004);
    add_vec(64'h4000, 32'hFE20E8E3, 1'b0, 4, decode_pkg::CLS_BRANCH, 64'hFFFF_FFFF_FFFF_FFF0,
            64'h2222, 1'b0, 5'd0, 1'b0, 64'h0);
    add_vec(64'h4000, 32'hFE20E8E3, 1'b1, 4, decode_pkg::CLS_BRANCH, 64'hFFFF_FFFF_FFFF_FFF0,
            64'h2222, 1'b0, 5'd0, 1'b1, 64'h4004);
    add_vec(64'h4000, 32'hFE20F8E3, 1'b0, 4, decode_pkg::CLS_BRANCH, 64'hFFFF_FFFF_FFFF_FFF0,
            64'h2222, 1'b0, 5'd0, 1'b1, 64'h3FF0);
    add_vec(64'h4000, 32'hFE20F8E3, 1'b1, 4, decode_pkg::CLS_BRANCH, 64'hFFFF_FFFF_FFFF_FFF0,
            64'h2222, 1'b0, 5'd0, 1'b0, 64'h0);
    add_vec(64'h4000, 32'hFE1088E3, 1'b0, 4, decode_pkg::CLS_BRANCH, 64'hFFFF_FFFF_FFFF_FFF0,
            64'hFFFF_FFFF_FFFF_FFF0, 1'b0, 5'd0, 1'b1, 64'h3FF0);
    // jalr, plain and with forwarded rs1
    add_vec(64'h5000, 32'h005100E7, 1'b1, 0, decode_pkg::CLS_JALR, 64'h2222, 64'h5000,
            1'b1, 5'd1, 1'b1, 64'h2226);
    add_vec(64'h5004, 32'hFFD28067, 1'b0, 1, decode_pkg::CLS_JALR, 64'hAAAA_0000_0000_0008,
            64'h5004, 1'b1, 5'd0, 1'b1, 64'hAAAA_0000_0000_0004);
  endtask

  task automatic apply_bypass(input int unsigned set);
    for (int j = 0; j < NUM_BYPASS; j++) begin
      bypass_i[j] <= bp_sets[set][j];
    end
  endtask

  // bypass set follows the packet once it is taken into the input register
  task automatic send_all();
    int unsigned last;
    last = vecs.size() - 1;
    for (int k = 0; k < vecs.size(); k++) begin
      in_valid_i <= 1'b1;
      in_pkt_i   <= vecs[k].fetch;
      do begin
        @(posedge clk);
        // previous packet still sits in the input register
        if (k > 0) begin
          check_rf_addr(k - 1, vecs[k-1].exp_rs1, vecs[k-1].exp_rs2, rf_rs1_addr_o,
                        rf_rs2_addr_o);
        end
      end while (!in_ready_o);
      apply_bypass(vecs[k].bp_set);
    end
    in_valid_i <= 1'b0;
    @(posedge clk);
    check_rf_addr(last, vecs[last].exp_rs1, vecs[last].exp_rs2, rf_rs1_addr_o, rf_rs2_addr_o);
  endtask

  task automatic collect_all(input bit random_ready);
    int          k;
    logic [31:0] rnd;
    k = 0;
    while (k < vecs.size()) begin
      @(posedge clk);
      if (out_valid_o && out_ready_i) begin
        check_pkt(k, vecs[k].exp, out_pkt_o);
        check_redirect(k, vecs[k].exp.redirect, vecs[k].exp.redirect_pc,
                       out_pkt_o.redirect, out_pkt_o.redirect_pc);
        k++;
      end
      rnd = $random(seed);
      out_ready_i <= random_ready ? rnd[0] : 1'b1;
    end
    out_ready_i <= 1'b1;
  endtask

  task automatic check_idle();
    repeat (4) begin
      @(posedge clk);
      if (out_valid_o) begin
        fail_now("unexpected extra packet on the output after the last vector");
      end
    end
  endtask

  initial begin
    seed        = 32'h4d5d;
    rst_n_i     = 1'b0;
    in_valid_i  = 1'b0;
    in_pkt_i    = '0;
    out_ready_i = 1'b0;
    for (int j = 0; j < NUM_BYPASS; j++) begin
      bypass_i[j] = '0;
    end
    load_bypass_sets();
    fill_table();
    table_ready = 1'b1;
    repeat (4) @(posedge clk);
    rst_n_i     <= 1'b1;
    out_ready_i <= 1'b1;
    // second pass replays the table under random back-pressure
    for (int p = 0; p < 2; p++) begin
      fork
        send_all();
        collect_all(p == 1);
      join
      check_idle();
    end
    if (decode_stage_i.decode_stage_assertions_i.fail_count != 0) begin
      fail_now("concurrent assertion failures were reported");
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

  initial begin
    wait (table_ready);
    repeat (vecs.size() * 2 * 40 + 100) @(posedge clk);
    fail_now("timeout waiting for the DUT to deliver all packets");
  end

endmodule

// ==== verif/decode_stage_assertions.sv ====
/*
 * decode stage output checks
 * handshake stability and packet sanity, bound into decode_stage
 */
`timescale 1ns/100ps

module decode_stage_assertions (
  input logic                    clk,
  input logic                    rst_n_i,
  input logic                    out_valid_i,
  input logic                    out_ready_i,
  input decode_pkg::decode_pkt_t out_pkt_i
);

  int unsigned fail_count = 0;

  valid_low_after_reset: assert property (@(posedge clk) !rst_n_i |=> !out_valid_i)
    else begin
      fail_count++;
      $error("out_valid_o high in the cycle after reset");
    end

  // stalled packet must not change under execute
  hold_while_stalled: assert property (@(posedge clk) disable iff (!rst_n_i)
    out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_pkt_i))
    else begin
      fail_count++;
      $error("out_valid_o or out_pkt_o changed while out_ready_i was low");
    end

  rd_addr_zero_without_we: assert property (@(posedge clk) disable iff (!rst_n_i)
    out_valid_i && !out_pkt_i.rd_we |-> out_pkt_i.rd_addr == '0)
    else begin
      fail_count++;
      $error("rd_addr nonzero on a packet that writes no register");
    end

endmodule

bind decode_stage decode_stage_assertions decode_stage_assertions_i (
  .clk         (clk),
  .rst_n_i     (rst_n_i),
  .out_valid_i (out_valid_o),
  .out_ready_i (out_ready_i),
  .out_pkt_i   (out_pkt_o)
);

// ==== logic/decode_stage.sv ====
/*
 * RV64 decode stage
 * input register, classify, operand forwarding, branch resolve, output register
 */
`timescale 1ns/100ps

module decode_stage #(
  parameter int unsigned NUM_BYPASS = decode_pkg::DEF_NUM_BYPASS
) (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  logic                    in_valid_i,
  output logic                    in_ready_o,
  input  decode_pkg::fetch_pkt_t  in_pkt_i,
  output decode_pkg::reg_addr_t   rf_rs1_addr_o,
  output decode_pkg::reg_addr_t   rf_rs2_addr_o,
  input  decode_pkg::xlen_t       rf_rs1_data_i,
  input  decode_pkg::xlen_t       rf_rs2_data_i,
  input  decode_pkg::bypass_t     bypass_i [NUM_BYPASS],
  output logic                    out_valid_o,
  input  logic                    out_ready_i,
  output decode_pkg::decode_pkt_t out_pkt_o
);

  logic                    advance;
  logic                    held_valid;
  decode_pkg::fetch_pkt_t  held_pkt;
  decode_pkg::inst_class_e cls;
  logic                    rs1_rd;
  logic                    rs2_rd;
  logic                    rd_we;
  decode_pkg::reg_addr_t   rd_addr;
  decode_pkg::xlen_t       i_imm;
  decode_pkg::xlen_t       u_imm;
  decode_pkg::xlen_t       b_target;
  decode_pkg::xlen_t       op1;
  decode_pkg::xlen_t       op2;
  logic                    redirect;
  decode_pkg::xlen_t       redirect_pc;
  decode_pkg::decode_pkt_t dec_pkt;

  decode_in_reg in_reg_i (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .in_valid_i   (in_valid_i),
    .in_ready_o   (in_ready_o),
    .in_pkt_i     (in_pkt_i),
    .advance_i    (advance),
    .held_valid_o (held_valid),
    .held_pkt_o   (held_pkt)
  );

  inst_classify classify_i (
    .inst_i     (held_pkt.inst),
    .pc_i       (held_pkt.pc),
    .cls_o      (cls),
    .rs1_rd_o   (rs1_rd),
    .rs2_rd_o   (rs2_rd),
    .rs1_addr_o (rf_rs1_addr_o),
    .rs2_addr_o (rf_rs2_addr_o),
    .rd_we_o    (rd_we),
    .rd_addr_o  (rd_addr),
    .i_imm_o    (i_imm),
    .u_imm_o    (u_imm),
    .b_target_o (b_target)
  );

  operand_bypass #(
    .NUM_BYPASS (NUM_BYPASS)
  ) bypass_sel_i (
    .cls_i         (cls),
    .rs1_rd_i      (rs1_rd),
    .rs2_rd_i      (rs2_rd),
    .rs1_addr_i    (rf_rs1_addr_o),
    .rs2_addr_i    (rf_rs2_addr_o),
    .rf_rs1_data_i (rf_rs1_data_i),
    .rf_rs2_data_i (rf_rs2_data_i),
    .bypass_i      (bypass_i),
    .pc_i          (held_pkt.pc),
    .i_imm_i       (i_imm),
    .u_imm_i       (u_imm),
    .op1_o         (op1),
    .op2_o         (op2)
  );

  // for a branch op2 is the forwarded rs2
  branch_resolve resolve_i (
    .cls_i         (cls),
    .funct3_i      (held_pkt.inst.r.funct3),
    .pred_taken_i  (held_pkt.pred_taken),
    .op1_i         (op1),
    .op2_i         (op2),
    .rs2_val_i     (op2),
    .pc_i          (held_pkt.pc),
    .i_imm_i       (i_imm),
    .b_target_i    (b_target),
    .redirect_o    (redirect),
    .redirect_pc_o (redirect_pc)
  );

  assign dec_pkt.pc          = held_pkt.pc;
  assign dec_pkt.cls         = cls;
  assign dec_pkt.funct3      = held_pkt.inst.r.funct3;
  assign dec_pkt.op1         = op1;
  assign dec_pkt.op2         = op2;
  assign dec_pkt.rd_we       = rd_we;
  assign dec_pkt.rd_addr     = rd_addr;
  assign dec_pkt.redirect    = redirect;
  assign dec_pkt.redirect_pc = redirect_pc;

  decode_out_reg out_reg_i (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .held_valid_i (held_valid),
    .pkt_i        (dec_pkt),
    .advance_o    (advance),
    .out_valid_o  (out_valid_o),
    .out_ready_i  (out_ready_i),
    .out_pkt_o    (out_pkt_o)
  );

endmodule

// ==== logic/decode_out_reg.sv ====
/*
 * decode output register
 * holds the decoded packet toward execute with valid/ready
 */
`timescale 1ns/100ps

module decode_out_reg (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  logic                    held_valid_i,
  input  decode_pkg::decode_pkt_t pkt_i,
  output logic                    advance_o,
  output logic                    out_valid_o,
  input  logic                    out_ready_i,
  output decode_pkg::decode_pkt_t out_pkt_o
);

  logic                    out_valid_q;
  decode_pkg::decode_pkt_t out_pkt_q;

  // empty, or execute takes the current packet this cycle
  assign advance_o = ~out_valid_q | out_ready_i;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      out_valid_q <= 1'b0;
    end else if (advance_o) begin
      out_valid_q <= held_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (advance_o && held_valid_i) begin
      out_pkt_q <= pkt_i;
    end
  end

  assign out_valid_o = out_valid_q;
  assign out_pkt_o   = out_pkt_q;

endmodule

// ==== logic/branch_resolve.sv ====
/*
 * branch resolution
 * evaluates conditional branches against the prediction, JALR always redirects
 */
`timescale 1ns/100ps

module branch_resolve (
  input  decode_pkg::inst_class_e cls_i,
  input  logic [2:0]              funct3_i,
  input  logic                    pred_taken_i,
  input  decode_pkg::xlen_t       op1_i,
  input  decode_pkg::xlen_t       op2_i,
  input  decode_pkg::xlen_t       rs2_val_i,
  input  decode_pkg::xlen_t       pc_i,
  input  decode_pkg::xlen_t       i_imm_i,
  input  decode_pkg::xlen_t       b_target_i,
  output logic                    redirect_o,
  output decode_pkg::xlen_t       redirect_pc_o
);

  logic [decode_pkg::XLEN:0] diff;
  logic                      eq;
  logic                      ltu;
  logic                      lt;
  logic                      taken;
  logic                      br_redirect;
  decode_pkg::xlen_t         br_pc;
  decode_pkg::xlen_t         jalr_sum;

  // borrow out of the wide subtract is the unsigned less-than
  assign diff = {1'b0, op1_i} - {1'b0, op2_i};
  assign ltu  = diff[decode_pkg::XLEN];
  assign lt   = (op1_i[decode_pkg::XLEN-1] ^ op2_i[decode_pkg::XLEN-1]) ?
                op1_i[decode_pkg::XLEN-1] : ltu;
  assign eq   = (op1_i == rs2_val_i);

  always_comb begin
    case (funct3_i)
      3'b000:  taken = eq;
      3'b001:  taken = ~eq;
      3'b100:  taken = lt;
      3'b101:  taken = ~lt;
      3'b110:  taken = ltu;
      3'b111:  taken = ~ltu;
      default: taken = 1'b0;
    endcase
  end

  assign br_redirect = (cls_i == decode_pkg::CLS_BRANCH) && (taken != pred_taken_i);
  // predicted taken but falls through, or the other way round
  assign br_pc = pred_taken_i ? pc_i + decode_pkg::XLEN'(4) : b_target_i;

  assign jalr_sum = op1_i + i_imm_i;

  always_comb begin
    if (br_redirect) begin
      redirect_o    = 1'b1;
      redirect_pc_o = br_pc;
    end else if (cls_i == decode_pkg::CLS_JALR) begin
      redirect_o    = 1'b1;
      redirect_pc_o = {jalr_sum[decode_pkg::XLEN-1:1], 1'b0};
    end else begin
      redirect_o    = 1'b0;
      redirect_pc_o = '0;
    end
  end

endmodule

// ==== logic/operand_bypass.sv ====
/*
 * operand selection
 * forwards from the youngest matching bypass source, then muxes op1/op2
 */
`timescale 1ns/100ps

module operand_bypass #(
  parameter int unsigned NUM_BYPASS = 3
) (
  input  decode_pkg::inst_class_e cls_i,
  input  logic                    rs1_rd_i,
  input  logic                    rs2_rd_i,
  input  decode_pkg::reg_addr_t   rs1_addr_i,
  input  decode_pkg::reg_addr_t   rs2_addr_i,
  input  decode_pkg::xlen_t       rf_rs1_data_i,
  input  decode_pkg::xlen_t       rf_rs2_data_i,
  input  decode_pkg::bypass_t     bypass_i [NUM_BYPASS],
  input  decode_pkg::xlen_t       pc_i,
  input  decode_pkg::xlen_t       i_imm_i,
  input  decode_pkg::xlen_t       u_imm_i,
  output decode_pkg::xlen_t       op1_o,
  output decode_pkg::xlen_t       op2_o
);

  decode_pkg::xlen_t rs1_val;
  decode_pkg::xlen_t rs2_val;

  // walk oldest to youngest so index 0 has the last word
  function automatic decode_pkg::xlen_t forward(input decode_pkg::reg_addr_t addr,
                                                input decode_pkg::xlen_t rf_data);
    decode_pkg::xlen_t val;
    val = rf_data;
    for (int i = NUM_BYPASS - 1; i >= 0; i--) begin
      if (bypass_i[i].ena && bypass_i[i].addr == addr && addr != '0) begin
        val = bypass_i[i].data;
      end
    end
    return val;
  endfunction

  always_comb begin
    rs1_val = forward(rs1_addr_i, rf_rs1_data_i);
    rs2_val = forward(rs2_addr_i, rf_rs2_data_i);
  end

  always_comb begin
    if (rs1_rd_i) begin
      op1_o = rs1_val;
    end else if (cls_i inside {decode_pkg::CLS_AUIPC, decode_pkg::CLS_JAL}) begin
      op1_o = pc_i;
    end else begin
      op1_o = '0;
    end
  end

  always_comb begin
    if (rs2_rd_i) begin
      op2_o = rs2_val;
    end else if (cls_i inside {decode_pkg::CLS_ALU_IMM, decode_pkg::CLS_ALU_IMM_W,
                               decode_pkg::CLS_LOAD}) begin
      op2_o = i_imm_i;
    end else if (cls_i inside {decode_pkg::CLS_LUI, decode_pkg::CLS_AUIPC}) begin
      op2_o = u_imm_i;
    end else if (cls_i inside {decode_pkg::CLS_JAL, decode_pkg::CLS_JALR}) begin
      // link base for execute
      op2_o = pc_i;
    end else begin
      op2_o = '0;
    end
  end

endmodule

// ==== logic/inst_classify.sv ====
/*
 * instruction classifier
 * major opcode to class, register usage and immediates
 */
`timescale 1ns/100ps

module inst_classify (
  input  decode_pkg::inst_u       inst_i,
  input  decode_pkg::xlen_t       pc_i,
  output decode_pkg::inst_class_e cls_o,
  output logic                    rs1_rd_o,
  output logic                    rs2_rd_o,
  output decode_pkg::reg_addr_t   rs1_addr_o,
  output decode_pkg::reg_addr_t   rs2_addr_o,
  output logic                    rd_we_o,
  output decode_pkg::reg_addr_t   rd_addr_o,
  output decode_pkg::xlen_t       i_imm_o,
  output decode_pkg::xlen_t       u_imm_o,
  output decode_pkg::xlen_t       b_target_o
);

  logic [4:0]  major;
  logic [12:0] b_off;

  assign major = inst_i.r.opcode[6:2];

  always_comb begin
    cls_o = decode_pkg::CLS_NONE;
    // compressed encodings and anything else fall out as none
    if (inst_i.r.opcode[1:0] == 2'b11) begin
      case (major)
        decode_pkg::OPC_ALU_REG:   cls_o = decode_pkg::CLS_ALU_REG;
        decode_pkg::OPC_ALU_IMM:   cls_o = decode_pkg::CLS_ALU_IMM;
        decode_pkg::OPC_ALU_REG_W: cls_o = decode_pkg::CLS_ALU_REG_W;
        decode_pkg::OPC_ALU_IMM_W: cls_o = decode_pkg::CLS_ALU_IMM_W;
        decode_pkg::OPC_BRANCH:    cls_o = decode_pkg::CLS_BRANCH;
        decode_pkg::OPC_LOAD:      cls_o = decode_pkg::CLS_LOAD;
        decode_pkg::OPC_STORE:     cls_o = decode_pkg::CLS_STORE;
        decode_pkg::OPC_LUI:       cls_o = decode_pkg::CLS_LUI;
        decode_pkg::OPC_AUIPC:     cls_o = decode_pkg::CLS_AUIPC;
        decode_pkg::OPC_JAL:       cls_o = decode_pkg::CLS_JAL;
        decode_pkg::OPC_JALR:      cls_o = decode_pkg::CLS_JALR;
        decode_pkg::OPC_SYSTEM:    cls_o = decode_pkg::CLS_SYSTEM;
        default:                   cls_o = decode_pkg::CLS_NONE;
      endcase
    end
  end

  assign rs1_rd_o = cls_o inside {decode_pkg::CLS_ALU_REG, decode_pkg::CLS_ALU_IMM,
                                  decode_pkg::CLS_ALU_REG_W, decode_pkg::CLS_ALU_IMM_W,
                                  decode_pkg::CLS_BRANCH, decode_pkg::CLS_LOAD,
                                  decode_pkg::CLS_STORE, decode_pkg::CLS_JALR};
  assign rs2_rd_o = cls_o inside {decode_pkg::CLS_ALU_REG, decode_pkg::CLS_ALU_REG_W,
                                  decode_pkg::CLS_BRANCH, decode_pkg::CLS_STORE};
  assign rd_we_o  = cls_o inside {decode_pkg::CLS_ALU_REG, decode_pkg::CLS_ALU_IMM,
                                  decode_pkg::CLS_ALU_REG_W, decode_pkg::CLS_ALU_IMM_W,
                                  decode_pkg::CLS_LOAD, decode_pkg::CLS_LUI,
                                  decode_pkg::CLS_AUIPC, decode_pkg::CLS_JAL,
                                  decode_pkg::CLS_JALR};

  assign rs1_addr_o = rs1_rd_o ? inst_i.r.rs1 : '0;
  assign rs2_addr_o = rs2_rd_o ? inst_i.r.rs2 : '0;
  assign rd_addr_o  = rd_we_o ? inst_i.r.rd : '0;

  assign i_imm_o = {{(decode_pkg::XLEN-12){inst_i.i.imm[11]}}, inst_i.i.imm};
  assign u_imm_o = {{(decode_pkg::XLEN-32){inst_i.u.imm[19]}}, inst_i.u.imm, 12'b0};

  // reassemble the scattered branch offset
  assign b_off = {inst_i.b.imm12, inst_i.b.imm11, inst_i.b.imm10_5, inst_i.b.imm4_1, 1'b0};
  assign b_target_o = pc_i + {{(decode_pkg::XLEN-13){b_off[12]}}, b_off};

endmodule

// ==== logic/decode_in_reg.sv ====
/*
 * decode input register
 * one-entry holding slot for fetch packets, valid/ready toward fetch
 */
`timescale 1ns/100ps

module decode_in_reg (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  input  decode_pkg::fetch_pkt_t in_pkt_i,
  input  logic                   advance_i,
  output logic                   held_valid_o,
  output decode_pkg::fetch_pkt_t held_pkt_o
);

  logic                   held_valid_q;
  decode_pkg::fetch_pkt_t held_pkt_q;

  // free slot, or the current entry moves on this edge
  assign in_ready_o = ~held_valid_q | advance_i;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      held_valid_q <= 1'b0;
    end else if (in_ready_o) begin
      held_valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (in_ready_o && in_valid_i) begin
      held_pkt_q <= in_pkt_i;
    end
  end

  assign held_valid_o = held_valid_q;
  assign held_pkt_o   = held_pkt_q;

endmodule

// ==== logic/decode_pkg.sv ====
/*
 * decode stage shared types
 * widths, instruction classes, format views and pipeline packets
 */
package decode_pkg;

  localparam int unsigned XLEN = 64;
  localparam int unsigned DEF_NUM_BYPASS = 3;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [4:0] reg_addr_t;

  typedef enum logic [3:0] {
    CLS_NONE      = 4'd0,
    CLS_ALU_REG   = 4'd1,
    CLS_ALU_IMM   = 4'd2,
    CLS_ALU_REG_W = 4'd3,
    CLS_ALU_IMM_W = 4'd4,
    CLS_BRANCH    = 4'd5,
    CLS_LOAD      = 4'd6,
    CLS_STORE     = 4'd7,
    CLS_LUI       = 4'd8,
    CLS_AUIPC     = 4'd9,
    CLS_JAL       = 4'd10,
    CLS_JALR      = 4'd11,
    CLS_SYSTEM    = 4'd12
  } inst_class_e;

  // major opcode, inst[6:2]
  localparam logic [4:0] OPC_LOAD      = 5'b00000;
  localparam logic [4:0] OPC_ALU_IMM   = 5'b00100;
  localparam logic [4:0] OPC_AUIPC     = 5'b00101;
  localparam logic [4:0] OPC_ALU_IMM_W = 5'b00110;
  localparam logic [4:0] OPC_STORE     = 5'b01000;
  localparam logic [4:0] OPC_ALU_REG   = 5'b01100;
  localparam logic [4:0] OPC_LUI       = 5'b01101;
  localparam logic [4:0] OPC_ALU_REG_W = 5'b01110;
  localparam logic [4:0] OPC_BRANCH    = 5'b11000;
  localparam logic [4:0] OPC_JALR      = 5'b11001;
  localparam logic [4:0] OPC_JAL       = 5'b11011;
  localparam logic [4:0] OPC_SYSTEM    = 5'b11100;

  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  // branch offset bits are scattered, bit 0 is implied zero
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
  } inst_u;

  typedef struct packed {
    xlen_t pc;
    inst_u inst;
    logic  pred_taken;
  } fetch_pkt_t;

  typedef struct packed {
    logic      ena;
    reg_addr_t addr;
    xlen_t     data;
  } bypass_t;

  typedef struct packed {
    xlen_t       pc;
    inst_class_e cls;
    logic [2:0]  funct3;
    xlen_t       op1;
    xlen_t       op2;
    logic        rd_we;
    reg_addr_t   rd_addr;
    logic        redirect;
    xlen_t       redirect_pc;
  } decode_pkt_t;

endpackage
